/* include/datapath_cfg.svh */
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

// Full datapath word
`define DP_WIDTH 64

// One Am2901 slice is a nibble
`define SLICE_WIDTH 4

// Slices needed to cover the word
`define SLICE_COUNT 16

// Register file depth inside each slice
`define REG_COUNT 16

`endif

/* rtl/aluPkg.sv */
`include "datapath_cfg.svh"

package aluPkg;

    // Operand and result of one slice
    typedef logic [`SLICE_WIDTH-1:0] sliceData;

    // Register file address, A and B ports
    typedef logic [$clog2(`REG_COUNT)-1:0] regAddr;

    // Whole datapath word
    typedef logic [`DP_WIDTH-1:0] wordData;

    // Destination, function and source fields, from bit 8 down
    typedef logic [8:0] aluInstr;

    // Source operand pairs, named R then S
    typedef enum logic [2:0] {
        AQ, AB, ZQ, ZB, ZA, DA, DQ, DZ
    } aluSource;

    // ALU function
    typedef enum logic [2:0] {
        ADD, SUBR, SUBS, OR, AND, NOTRS, EXOR, EXNOR
    } aluFunc;

    // Destination control
    // Bit 2 marks the shift codes, bit 1 picks the up direction
    // and bit 0 clear means Q shifts along with F
    typedef enum logic [2:0] {
        QREG, NOP, RAMA, RAMF, RAMQD, RAMD, RAMQU, RAMU
    } aluDest;

endpackage

/* rtl/statusPkg.sv */
package statusPkg;

    // Status and shift instruction word
    typedef logic [12:0] statusInstr;

    // Flags as Z, N, C, V from the top bit down
    typedef logic [3:0] statusFlags;

    // Bit positions inside statusFlags
    localparam int FLAG_Z = 3;
    localparam int FLAG_N = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // Register operation, bits 1..0
    typedef enum logic [1:0] {
        LOAD_ALU, LOAD_Y, CLEAR, HOLD
    } statusOp;

    // Condition test, bits 4..2
    typedef enum logic [2:0] {
        TZ, TNZ, TC, TNC, TN, TNN, TV, TNXV
    } condSel;

    // Open end fill on shifts, bits 7..6
    typedef enum logic [1:0] {
        FILL_ZERO, FILL_ROTATE, FILL_SIGN, FILL_CARRY
    } shiftFill;

    // Slice carry-in source, bits 12..11
    typedef enum logic [1:0] {
        CIN_ZERO, CIN_ONE, CIN_EXT, CIN_MICRO
    } carrySel;

endpackage

/* rtl/am2901.sv */
`timescale 1ns/100ps
`include "datapath_cfg.svh"

module am2901 (
    input  logic              clk,
    input  logic              reset,
    input  aluPkg::aluInstr   instr,
    input  aluPkg::regAddr    addrA,
    input  aluPkg::regAddr    addrB,
    input  aluPkg::sliceData  dataIn,
    input  logic              carryIn,
    input  logic              ramLowIn,
    input  logic              ramHighIn,
    input  logic              qLowIn,
    input  logic              qHighIn,
    output aluPkg::sliceData  y,
    output logic              ramLowOut,
    output logic              ramHighOut,
    output logic              qLowOut,
    output logic              qHighOut,
    output logic              carryOut,
    output logic              genN,
    output logic              propN,
    output logic              overflow,
    output logic              sign,
    output logic              zero
);
    import aluPkg::*;

    localparam int TOP = `SLICE_WIDTH - 1;

    aluSource src;
    aluFunc   func;
    aluDest   dest;

    sliceData regFile [`REG_COUNT];
    sliceData qReg;
    sliceData aData, bData;
    sliceData r, s, rEff, sEff, f;
    sliceData gen, prop;
    sliceData ramData, qData;
    logic [`SLICE_WIDTH:0] sum;
    logic regWrite, qWrite;

    // Instruction fields
    assign src  = aluSource'(instr[2:0]);
    assign func = aluFunc'(instr[5:3]);
    assign dest = aluDest'(instr[8:6]);

    // Both register ports read in the same cycle
    assign aData = regFile[addrA];
    assign bData = regFile[addrB];

    // R operand
    always_comb begin
        unique case (src)
            AQ, AB:     r = aData;
            ZQ, ZB, ZA: r = '0;
            default:    r = dataIn;
        endcase
    end

    // S operand
    always_comb begin
        unique case (src)
            AQ, ZQ, DQ: s = qReg;
            AB, ZB:     s = bData;
            ZA, DA:     s = aData;
            default:    s = '0;
        endcase
    end

    // Subtraction as addition of the complement
    assign rEff = (func == SUBR) ? ~r : r;
    assign sEff = (func == SUBS) ? ~s : s;
    assign sum  = {1'b0, rEff} + {1'b0, sEff} + {{`SLICE_WIDTH{1'b0}}, carryIn};

    always_comb begin
        unique case (func)
            ADD, SUBR, SUBS: f = sum[TOP:0];
            OR:              f = r | s;
            AND:             f = r & s;
            NOTRS:           f = ~r & s;
            EXOR:            f = r ^ s;
            default:         f = ~(r ^ s);
        endcase
    end

    // Active-low generate and propagate for the Am2902
    assign gen   = rEff & sEff;
    assign prop  = rEff | sEff;
    assign genN  = ~(gen[3] | (prop[3] & gen[2]) | (prop[3] & prop[2] & gen[1]) |
                     (prop[3] & prop[2] & prop[1] & gen[0]));
    assign propN = ~&prop;

    // Flags
    assign carryOut = sum[`SLICE_WIDTH];
    // Carry into the top bit differs from carry out on overflow
    assign overflow = sum[`SLICE_WIDTH] ^ (rEff[TOP] ^ sEff[TOP] ^ sum[TOP]);
    assign sign     = f[TOP];
    assign zero     = (f == '0);

    assign y = (dest == RAMA) ? aData : f;

    // End bits offered to the neighbours
    assign ramLowOut  = f[0];
    assign ramHighOut = f[TOP];
    assign qLowOut    = qReg[0];
    assign qHighOut   = qReg[TOP];

    // Register file data, shifted for the shift codes
    always_comb begin
        if (!dest[2]) begin
            ramData = f;
        end else if (dest[1]) begin
            ramData = {f[TOP-1:0], ramLowIn};
        end else begin
            ramData = {ramHighIn, f[TOP:1]};
        end
    end

    // Q register data
    always_comb begin
        if (!dest[2]) begin
            qData = f;
        end else if (dest[1]) begin
            qData = {qReg[TOP-1:0], qLowIn};
        end else begin
            qData = {qHighIn, qReg[TOP:1]};
        end
    end

    // QREG and NOP leave the register file alone
    assign regWrite = dest[2] | dest[1];
    assign qWrite   = (dest == QREG) || (dest[2] && !dest[0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
            qReg <= '0;
        end else begin
            if (regWrite) begin
                regFile[addrB] <= ramData;
            end
            if (qWrite) begin
                qReg <= qData;
            end
        end
    end

    // Only QREG may touch Q outside the shift codes
    qHoldCheck: assert property (@(posedge clk) disable iff (reset)
        (!dest[2] && dest != QREG) |=> $stable(qReg));

endmodule

/* rtl/am2902.sv */
`timescale 1ns/100ps

module am2902 (
    input  logic       carryIn,
    input  logic [3:0] genN,
    input  logic [3:0] propN,
    output logic       carryX,
    output logic       carryY,
    output logic       carryZ,
    output logic       groupGenN,
    output logic       groupPropN
);

    always_comb begin
        logic       ripple;
        logic [2:0] rippleCarry;

        // Lookahead carries into groups 1, 2 and 3
        carryX = ~genN[0] | (~propN[0] & carryIn);
        carryY = ~genN[1] | (~propN[1] & ~genN[0]) | (~propN[1] & ~propN[0] & carryIn);
        carryZ = ~genN[2] | (~propN[2] & ~genN[1]) | (~propN[2] & ~propN[1] & ~genN[0]) |
                 (~propN[2] & ~propN[1] & ~propN[0] & carryIn);

        // Block generate and propagate for the next level
        groupGenN = ~(~genN[3] | (~propN[3] & ~genN[2]) | (~propN[3] & ~propN[2] & ~genN[1]) |
                      (~propN[3] & ~propN[2] & ~propN[1] & ~genN[0]));
        groupPropN = |propN;

        // Same carries, rippled group by group
        ripple = carryIn;
        for (int i = 0; i < 3; i++) begin
            ripple         = ~genN[i] | (~propN[i] & ripple);
            rippleCarry[i] = ripple;
        end

        lookaheadCheck: assert ({carryZ, carryY, carryX} == rippleCarry);
    end

endmodule

/* rtl/am2904.sv */
`timescale 1ns/100ps

module am2904 (
    input  logic                  clk,
    input  logic                  reset,
    input  statusPkg::statusInstr instr,
    input  logic                  machineEnableN,
    input  logic                  microEnableN,
    input  statusPkg::statusFlags flags,
    input  statusPkg::statusFlags yIn,
    input  logic                  extCarry,
    input  logic                  shiftEnableN,
    input  logic                  ramLowIn,
    input  logic                  ramHighIn,
    input  logic                  qLowIn,
    input  logic                  qHighIn,
    output statusPkg::statusFlags yOut,
    output logic                  condTest,
    output logic                  sliceCarry,
    output logic                  ramLowOut,
    output logic                  ramHighOut,
    output logic                  qLowOut,
    output logic                  qHighOut
);
    import statusPkg::*;

    statusOp    op;
    condSel     cond;
    shiftFill   fill;
    carrySel    cinSel;
    logic       useMachine, shiftUp;
    statusFlags microReg, machineReg, testReg;
    logic       ramFill, qFill, shiftOn;

    // Same register update for micro and machine status
    function automatic statusFlags applyOp(statusOp opIn, statusFlags cur,
                                           statusFlags aluFlags, statusFlags busFlags);
        unique case (opIn)
            LOAD_ALU: return aluFlags;
            LOAD_Y:   return busFlags;
            CLEAR:    return '0;
            default:  return cur;
        endcase
    endfunction

    assign op         = statusOp'(instr[1:0]);
    assign cond       = condSel'(instr[4:2]);
    assign useMachine = instr[5];
    assign fill       = shiftFill'(instr[7:6]);
    assign shiftUp    = instr[10];
    assign cinSel     = carrySel'(instr[12:11]);

    always_ff @(posedge clk) begin
        if (reset) begin
            microReg   <= '0;
            machineReg <= '0;
        end else begin
            if (!microEnableN) begin
                microReg <= applyOp(op, microReg, flags, yIn);
            end
            if (!machineEnableN) begin
                machineReg <= applyOp(op, machineReg, flags, yIn);
            end
        end
    end

    // Register under test, also read back on Y
    assign testReg = useMachine ? machineReg : microReg;
    assign yOut    = testReg;

    always_comb begin
        unique case (cond)
            TZ:      condTest = testReg[FLAG_Z];
            TNZ:     condTest = !testReg[FLAG_Z];
            TC:      condTest = testReg[FLAG_C];
            TNC:     condTest = !testReg[FLAG_C];
            TN:      condTest = testReg[FLAG_N];
            TNN:     condTest = !testReg[FLAG_N];
            TV:      condTest = testReg[FLAG_V];
            default: condTest = testReg[FLAG_N] ^ testReg[FLAG_V];
        endcase
    end

    // Bit entering the open end of F and of Q
    always_comb begin
        unique case (fill)
            FILL_ZERO: begin
                ramFill = 1'b0;
                qFill   = 1'b0;
            end
            FILL_ROTATE: begin
                ramFill = shiftUp ? ramHighIn : ramLowIn;
                qFill   = shiftUp ? qHighIn : qLowIn;
            end
            FILL_SIGN: begin
                // Sign copy only makes sense going down
                ramFill = !shiftUp && ramHighIn;
                qFill   = !shiftUp && qHighIn;
            end
            default: begin
                ramFill = microReg[FLAG_C];
                qFill   = microReg[FLAG_C];
            end
        endcase
    end

    // Up shifts fill the low end, down shifts the high end
    assign shiftOn    = !shiftEnableN;
    assign ramLowOut  = shiftOn && shiftUp && ramFill;
    assign qLowOut    = shiftOn && shiftUp && qFill;
    assign ramHighOut = shiftOn && !shiftUp && ramFill;
    assign qHighOut   = shiftOn && !shiftUp && qFill;

    always_comb begin
        unique case (cinSel)
            CIN_ZERO: sliceCarry = 1'b0;
            CIN_ONE:  sliceCarry = 1'b1;
            CIN_EXT:  sliceCarry = extCarry;
            default:  sliceCarry = microReg[FLAG_C];
        endcase
    end

    microHoldCheck: assert property (@(posedge clk) disable iff (reset)
        microEnableN |=> $stable(microReg));

    machineHoldCheck: assert property (@(posedge clk) disable iff (reset)
        machineEnableN |=> $stable(machineReg));

endmodule

/* rtl/datapath.sv */
`timescale 1ns/100ps
`include "datapath_cfg.svh"

module datapath (
    input  logic                  clk,
    input  logic                  reset,
    input  aluPkg::aluInstr       aluInstr,
    input  aluPkg::regAddr        addrA,
    input  aluPkg::regAddr        addrB,
    input  aluPkg::wordData       dataIn,
    input  logic                  carryIn,
    input  logic                  mode64,
    output aluPkg::wordData       yAlu,
    input  statusPkg::statusInstr statusInstr,
    input  logic                  machineEnableN,
    input  logic                  microEnableN,
    input  statusPkg::statusFlags yStatusIn,
    output statusPkg::statusFlags yStatusOut,
    output logic                  condTest
);
    import aluPkg::*;
    import statusPkg::*;

    localparam int HALF      = `SLICE_COUNT / 2;
    localparam int TOP_SLICE = `SLICE_COUNT - 1;

    aluDest upperDest;
    logic [$bits(aluInstr)-1:0] upperInstr;

    // Per-slice status and links
    logic [`SLICE_COUNT-1:0] sliceGenN, slicePropN;
    logic [`SLICE_COUNT-1:0] sliceZero, sliceSign, sliceOverflow;
    logic [`SLICE_COUNT-1:0] ramUp, ramDown, qUp, qDown;
    logic [`SLICE_COUNT-1:0] ramLowIn, ramHighIn, qLowIn, qHighIn;
    // carry[i] enters slice i, the last one leaves the word
    logic [`SLICE_COUNT:0]   carry;
    logic [3:0]              groupGenN, groupPropN;
    logic                    topGenN, topPropN;

    statusFlags aluFlags;
    logic       linkRamLow, linkRamHigh, linkQLow, linkQHigh;
    logic       endRamHigh, endQHigh;

    // Upper half may not write its registers in 32-bit mode
    assign upperDest  = mode64 ? aluDest'(aluInstr[8:6]) : NOP;
    assign upperInstr = {upperDest, aluInstr[5:0]};

    genvar i;
    generate
        for (i = 0; i < `SLICE_COUNT; i++) begin : slices
            am2901 slice (
                .clk       (clk),
                .reset     (reset),
                .instr     ((i >= HALF) ? upperInstr : aluInstr),
                .addrA     (addrA),
                .addrB     (addrB),
                .dataIn    (dataIn[i*`SLICE_WIDTH +: `SLICE_WIDTH]),
                .carryIn   (carry[i]),
                .ramLowIn  (ramLowIn[i]),
                .ramHighIn (ramHighIn[i]),
                .qLowIn    (qLowIn[i]),
                .qHighIn   (qHighIn[i]),
                .y         (yAlu[i*`SLICE_WIDTH +: `SLICE_WIDTH]),
                .ramLowOut (ramDown[i]),
                .ramHighOut(ramUp[i]),
                .qLowOut   (qDown[i]),
                .qHighOut  (qUp[i]),
                .carryOut  (),
                .genN      (sliceGenN[i]),
                .propN     (slicePropN[i]),
                .overflow  (sliceOverflow[i]),
                .sign      (sliceSign[i]),
                .zero      (sliceZero[i])
            );
        end

        // First level, four slices per unit
        for (i = 0; i < 4; i++) begin : groups
            am2902 lookahead (
                .carryIn   (carry[4*i]),
                .genN      (sliceGenN[4*i +: 4]),
                .propN     (slicePropN[4*i +: 4]),
                .carryX    (carry[4*i+1]),
                .carryY    (carry[4*i+2]),
                .carryZ    (carry[4*i+3]),
                .groupGenN (groupGenN[i]),
                .groupPropN(groupPropN[i])
            );
        end
    endgenerate

    // Second level, carries into slices 4, 8 and 12
    am2902 topLookahead (
        .carryIn   (carry[0]),
        .genN      (groupGenN),
        .propN     (groupPropN),
        .carryX    (carry[4]),
        .carryY    (carry[8]),
        .carryZ    (carry[12]),
        .groupGenN (topGenN),
        .groupPropN(topPropN)
    );

    // Carry out of bit 63
    assign carry[`SLICE_COUNT] = ~topGenN | (~topPropN & carry[0]);

    // Flags from bit 31 or bit 63
    assign aluFlags = mode64
        ? {&sliceZero, sliceSign[TOP_SLICE], carry[`SLICE_COUNT], sliceOverflow[TOP_SLICE]}
        : {&sliceZero[HALF-1:0], sliceSign[HALF-1], carry[HALF], sliceOverflow[HALF-1]};

    // Word ends seen by the status unit
    assign endRamHigh = mode64 ? ramUp[TOP_SLICE] : ramUp[HALF-1];
    assign endQHigh   = mode64 ? qUp[TOP_SLICE] : qUp[HALF-1];

    // Up links run low to high, down links high to low
    // Slice 7 takes the status unit's fill when the word ends at bit 31
    assign ramLowIn  = {ramUp[TOP_SLICE-1:0], linkRamLow};
    assign qLowIn    = {qUp[TOP_SLICE-1:0], linkQLow};
    assign ramHighIn = {linkRamHigh, ramDown[TOP_SLICE:HALF+1],
                        mode64 ? ramDown[HALF] : linkRamHigh, ramDown[HALF-1:1]};
    assign qHighIn   = {linkQHigh, qDown[TOP_SLICE:HALF+1],
                        mode64 ? qDown[HALF] : linkQHigh, qDown[HALF-1:1]};

    // Shift linkage is on whenever the ALU destination shifts
    am2904 status (
        .clk           (clk),
        .reset         (reset),
        .instr         (statusInstr),
        .machineEnableN(machineEnableN),
        .microEnableN  (microEnableN),
        .flags         (aluFlags),
        .yIn           (yStatusIn),
        .extCarry      (carryIn),
        .shiftEnableN  (~aluInstr[8]),
        .ramLowIn      (ramDown[0]),
        .ramHighIn     (endRamHigh),
        .qLowIn        (qDown[0]),
        .qHighIn       (endQHigh),
        .yOut          (yStatusOut),
        .condTest      (condTest),
        .sliceCarry    (carry[0]),
        .ramLowOut     (linkRamLow),
        .ramHighOut    (linkRamHigh),
        .qLowOut       (linkQLow),
        .qHighOut      (linkQHigh)
    );

endmodule

/* tb/datapathTb.sv */
`timescale 1ns/100ps
`include "datapath_cfg.svh"

module datapathTb;
    import aluPkg::*;
    import statusPkg::*;

    logic       clk;
    logic       reset;
    logic [8:0] aluCode;
    regAddr     addrA;
    regAddr     addrB;
    wordData    dataIn;
    logic       carryIn;
    logic       mode64;
    wordData    yAlu;
    statusInstr statusCode;
    logic       machineEnableN;
    logic       microEnableN;
    statusFlags yStatusIn;
    statusFlags yStatusOut;
    logic       condTest;

    // Reference copy of the register files and both status registers
    wordData    model [`REG_COUNT];
    statusFlags microModel, machineModel;

    // What the DUT must show at the next rising edge
    wordData    expY;
    statusFlags expStatus;
    logic       expCond;

    logic [31:0] lfsrState;
    int          edgeCount;
    int          failCount, testStartFails, passTests, failTests;
    string       testName;

    datapath UUT (
        .clk           (clk),
        .reset         (reset),
        .aluInstr      (aluCode),
        .addrA         (addrA),
        .addrB         (addrB),
        .dataIn        (dataIn),
        .carryIn       (carryIn),
        .mode64        (mode64),
        .yAlu          (yAlu),
        .statusInstr   (statusCode),
        .machineEnableN(machineEnableN),
        .microEnableN  (microEnableN),
        .yStatusIn     (yStatusIn),
        .yStatusOut    (yStatusOut),
        .condTest      (condTest)
    );

    // 40 ns period
    always begin
        #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
    end

    // ALU word against the register model
    yAluCheck: assert property (@(posedge clk) disable iff (reset) yAlu == expY)
        else begin
            failCount++;
            $display("Fail %s yAlu expected %h actual %h", testName, expY, $sampled(yAlu));
        end

    // Selected status register on the Y bus
    yStatusCheck: assert property (@(posedge clk) disable iff (reset) yStatusOut == expStatus)
        else begin
            failCount++;
            $display("Fail %s yStatusOut expected %h actual %h", testName, expStatus,
                     $sampled(yStatusOut));
        end

    condCheck: assert property (@(posedge clk) disable iff (reset) condTest == expCond)
        else begin
            failCount++;
            $display("Fail %s condTest expected %b actual %b", testName, expCond,
                     $sampled(condTest));
        end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic wordData randomBits(int n);
        wordData value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value     = {value[62:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [8:0] aluWord(aluDest dest, aluFunc func, aluSource src);
        return {dest, func, src};
    endfunction

    function automatic statusInstr statusWord(statusOp op, condSel cond, logic useMachine,
                                              shiftFill fill, logic up, carrySel cin);
        return {cin, up, 2'b00, fill, useMachine, cond, op};
    endfunction

    function automatic statusInstr idleStatus();
        return statusWord(HOLD, TZ, 1'b0, FILL_ZERO, 1'b0, CIN_ZERO);
    endfunction

    // Function table of the ALU, full word with modular arithmetic
    function automatic wordData aluResult(aluFunc func, wordData r, wordData s, logic cin);
        case (func)
            ADD:     return r + s + cin;
            SUBR:    return ~r + s + cin;
            SUBS:    return r + ~s + cin;
            OR:      return r | s;
            AND:     return r & s;
            NOTRS:   return ~r & s;
            EXOR:    return r ^ s;
            default: return ~(r ^ s);
        endcase
    endfunction

    // Z N C V of a plain addition, taken at bit 63 or bit 31
    function automatic statusFlags addFlags(wordData a, wordData b, logic wide);
        logic [64:0] sum;
        if (wide) begin
            sum = {1'b0, a} + {1'b0, b};
            return {sum[63:0] == '0, sum[63], sum[64], (a[63] == b[63]) && (sum[63] != a[63])};
        end else begin
            sum = {33'd0, a[31:0]} + {33'd0, b[31:0]};
            return {sum[31:0] == '0, sum[31], sum[32], (a[31] == b[31]) && (sum[31] != a[31])};
        end
    endfunction

    function automatic logic condValue(condSel sel, statusFlags f);
        case (sel)
            TZ:      return f[3];
            TNZ:     return !f[3];
            TC:      return f[1];
            TNC:     return !f[1];
            TN:      return f[2];
            TNN:     return !f[2];
            TV:      return f[0];
            default: return f[2] ^ f[0];
        endcase
    endfunction

    // Register value after a shift, open end filled as selected
    function automatic wordData shifted(wordData f, logic up, shiftFill fill, logic wide,
                                        logic carry, wordData old);
        int      top;
        logic    endBit;
        wordData res;
        top = wide ? 63 : 31;
        case (fill)
            FILL_ZERO:   endBit = 1'b0;
            FILL_ROTATE: endBit = up ? f[top] : f[0];
            FILL_SIGN:   endBit = up ? 1'b0 : f[top];
            default:     endBit = carry;
        endcase
        if (up) begin
            res = {f[62:0], endBit};
        end else begin
            res      = {1'b0, f[63:1]};
            res[top] = endBit;
        end
        // Upper half untouched in 32-bit mode
        if (!wide) begin
            res = {old[63:32], res[31:0]};
        end
        return res;
    endfunction

    // Waits for the next rising edge, then steps past it
    task automatic nextCycle();
        int start;
        int waited;
        start  = edgeCount;
        waited = 0;
        while (edgeCount == start && waited < 100) begin
            #1;
            waited++;
        end
        if (edgeCount == start) begin
            $display("Timed out waiting for a rising clock edge");
            $display("** FAIL **");
            $finish;
        end else begin
            #2;
        end
    endtask

    // Drives one microinstruction, status expectations come from the current model
    task automatic runCycle(input logic [8:0] alu, input regAddr a, input regAddr b,
                            input wordData d, input statusInstr st, input wordData yExp);
        statusFlags sel;
        aluCode    = alu;
        addrA      = a;
        addrB      = b;
        dataIn     = d;
        statusCode = st;
        sel        = st[5] ? machineModel : microModel;
        expY       = yExp;
        expStatus  = sel;
        expCond    = condValue(condSel'(st[4:2]), sel);
        nextCycle();
    endtask

    task automatic loadReg(input regAddr dst, input wordData value);
        runCycle(aluWord(RAMF, ADD, DZ), 4'd0, dst, value, idleStatus(), value);
        if (mode64) begin
            model[dst] = value;
        end else begin
            model[dst][31:0] = value[31:0];
        end
    endtask

    task automatic readReg(input regAddr src);
        runCycle(aluWord(NOP, OR, ZA), src, 4'd0, '0, idleStatus(), model[src]);
    endtask

    task automatic statusCycle(input statusInstr st);
        runCycle(aluWord(NOP, OR, ZA), 4'd0, 4'd0, '0, st, model[0]);
    endtask

    task automatic beginTest(input string name);
        testName       = name;
        testStartFails = failCount;
    endtask

    task automatic endTest();
        if (failCount == testStartFails) begin
            $display("Test %s passed", testName);
            passTests++;
        end else begin
            $display("Test %s failed with %0d errors", testName, failCount - testStartFails);
            failTests++;
        end
    endtask

    initial begin
        regAddr  ra, rb;
        logic    cin;
        logic    upBit;
        carrySel cinSrc;
        clk            = 1'b0;
        reset          = 1'b1;
        aluCode        = aluWord(NOP, OR, ZA);
        addrA          = '0;
        addrB          = '0;
        dataIn         = '0;
        carryIn        = 1'b0;
        mode64         = 1'b1;
        statusCode     = idleStatus();
        machineEnableN = 1'b1;
        microEnableN   = 1'b1;
        yStatusIn      = '0;
        lfsrState      = 32'hd4ceb1b5;
        edgeCount      = 0;
        failCount      = 0;
        testStartFails = 0;
        passTests      = 0;
        failTests      = 0;
        testName       = "reset";
        expY           = '0;
        expStatus      = '0;
        expCond        = 1'b0;
        microModel     = '0;
        machineModel   = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end

        for (int i = 0; i < 8; i++) begin
            nextCycle();
        end
        reset = 1'b0;

        // Cleared registers, all eight tests on both status registers
        beginTest("reset");
        for (int r = 0; r < 16; r++) begin
            runCycle(aluWord(NOP, OR, ZA), r[3:0], 4'd0, '0,
                     statusWord(HOLD, condSel'(r[2:0]), r[3], FILL_ZERO, 1'b0, CIN_ZERO),
                     64'd0);
        end
        endTest();

        beginTest("arithmetic");
        for (int k = 0; k < 4; k++) begin
            rb = 4'(randomBits(4));
            loadReg(rb, randomBits(64));
            ra = 4'(randomBits(4));
            for (int f = 0; f < 8; f++) begin
                carryIn = 1'(randomBits(1));
                // Add takes the external carry, subtractions a forced one
                cinSrc  = (f == 0) ? CIN_EXT : (f < 3) ? CIN_ONE : CIN_ZERO;
                cin     = (f == 0) ? carryIn : (f < 3);
                runCycle(aluWord(NOP, aluFunc'(f[2:0]), AB), ra, rb, '0,
                         statusWord(HOLD, TZ, 1'b0, FILL_ZERO, 1'b0, cinSrc),
                         aluResult(aluFunc'(f[2:0]), model[ra], model[rb], cin));
            end
        end
        carryIn = 1'b0;
        endTest();

        beginTest("mode32");
        for (int k = 0; k < 4; k++) begin
            rb     = 4'(randomBits(4));
            mode64 = 1'b0;
            loadReg(rb, randomBits(64));
            mode64 = 1'b1;
            readReg(rb);
        end
        endTest();

        beginTest("status");
        for (int m = 1; m >= 0; m--) begin
            mode64 = m[0];
            for (int j = 0; j < 2; j++) begin
                ra = 4'(randomBits(4));
                rb = 4'(randomBits(4));
                // Second pass adds a value to its negation for a zero result
                if (j == 1) begin
                    rb = ra ^ 4'd1;
                    loadReg(rb, -model[ra]);
                end
                microEnableN = 1'b0;
                runCycle(aluWord(NOP, ADD, AB), ra, rb, '0,
                         statusWord(LOAD_ALU, TZ, 1'b0, FILL_ZERO, 1'b0, CIN_ZERO),
                         model[ra] + model[rb]);
                microModel   = addFlags(model[ra], model[rb], mode64);
                microEnableN = 1'b1;
                readReg(4'd0);
            end
        end
        mode64 = 1'b1;
        yStatusIn      = 4'(randomBits(4));
        microEnableN   = 1'b0;
        machineEnableN = 1'b0;
        statusCycle(statusWord(LOAD_Y, TZ, 1'b0, FILL_ZERO, 1'b0, CIN_ZERO));
        microModel   = yStatusIn;
        machineModel = yStatusIn;
        microEnableN = 1'b1;
        statusCycle(statusWord(CLEAR, TC, 1'b1, FILL_ZERO, 1'b0, CIN_ZERO));
        machineModel   = '0;
        machineEnableN = 1'b1;
        yStatusIn      = ~yStatusIn;
        // Both enables high, bus value must be ignored
        statusCycle(statusWord(LOAD_Y, TN, 1'b1, FILL_ZERO, 1'b0, CIN_ZERO));
        statusCycle(statusWord(HOLD, TNXV, 1'b0, FILL_ZERO, 1'b0, CIN_ZERO));
        statusCycle(statusWord(HOLD, TV, 1'b1, FILL_ZERO, 1'b0, CIN_ZERO));
        endTest();

        beginTest("shifts");
        for (int m = 1; m >= 0; m--) begin
            for (int fl = 0; fl < 4; fl++) begin
                for (int up = 0; up < 2; up++) begin
                    upBit  = up[0];
                    ra     = 4'(randomBits(4));
                    rb     = 4'(randomBits(4));
                    mode64 = 1'b1;
                    loadReg(ra, randomBits(64));
                    mode64 = m[0];
                    // F passes A through, the shifted copy lands in B
                    runCycle(aluWord(upBit ? RAMU : RAMD, OR, ZA), ra, rb, '0,
                             statusWord(HOLD, TZ, 1'b0, shiftFill'(fl[1:0]), upBit, CIN_ZERO),
                             model[ra]);
                    model[rb] = shifted(model[ra], upBit, shiftFill'(fl[1:0]), m[0],
                                        microModel[1], model[rb]);
                    mode64 = 1'b1;
                    readReg(rb);
                end
            end
        end
        endTest();

        beginTest("conditions");
        for (int k = 0; k < 4; k++) begin
            ra           = 4'(randomBits(4));
            rb           = 4'(randomBits(4));
            mode64       = k[0];
            microEnableN = 1'b0;
            runCycle(aluWord(NOP, ADD, AB), ra, rb, '0,
                     statusWord(LOAD_ALU, TZ, 1'b0, FILL_ZERO, 1'b0, CIN_ZERO),
                     model[ra] + model[rb]);
            microModel     = addFlags(model[ra], model[rb], mode64);
            microEnableN   = 1'b1;
            machineEnableN = 1'b0;
            yStatusIn      = 4'(randomBits(4));
            statusCycle(statusWord(LOAD_Y, TZ, 1'b0, FILL_ZERO, 1'b0, CIN_ZERO));
            machineModel   = yStatusIn;
            machineEnableN = 1'b1;
            mode64         = 1'b1;
            for (int c = 0; c < 16; c++) begin
                statusCycle(statusWord(HOLD, condSel'(c[2:0]), c[3], FILL_ZERO, 1'b0,
                                       CIN_ZERO));
            end
        end
        endTest();

        $display("Tests passed %0d, tests failed %0d, failed checks %0d",
                 passTests, failTests, failCount);
        if (failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
rtl/aluPkg.sv
rtl/statusPkg.sv
rtl/am2901.sv
rtl/am2902.sv
rtl/am2904.sv
rtl/datapath.sv
tb/datapathTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the datapath testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f all.f --top-module datapathTb \
    -Mdir "$BUILD_DIR" -o datapathSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/datapathSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG_FILE"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
